//--- dv/erx_chk.sv
/* erx bound checks
   register bus readback and receive strobe timing */

`default_nettype none

module erx_chk (
   input wire                        clk,
   input wire                        reset,
   input wire                        mi_en,
   input wire                        mi_we,
   input wire erx_txn_pkg::mi_data_t mi_dout,
   input wire                        out_access,
   input wire                        test_access,
   input wire                        drop_disabled,
   input wire                        drop_reserved,
   input wire                        timeout,
   input wire                        load_taps
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [3:0] results;                    // one per receive outcome
   assign results = {out_access, test_access, drop_disabled, drop_reserved};

   // ####################
   // readback only after a read strobe
   dout_idle_a: assert property (@(posedge clk) disable iff (reset)
      !$past(mi_en && !mi_we) |-> (mi_dout == '0))
      else $error("mi_dout nonzero without a read on the cycle before");

   // exactly one outcome per transaction
   outcome_a: assert property (@(posedge clk) disable iff (reset) $onehot0(results))
      else $error("more than one receive outcome strobe at once");

   taps_pulse_a: assert property (@(posedge clk) disable iff (reset)
      load_taps |=> !load_taps)
      else $error("load_taps held for two cycles");

   // first cycle out of reset is quiet
   reset_quiet_a: assert property (@(posedge clk)
      $fell(reset) |=> !(|results || timeout || load_taps))
      else $error("output strobe right after reset release");

endmodule

bind erx_top erx_chk i_chk (
   .clk, .reset, .mi_en, .mi_we, .mi_dout,
   .out_access, .test_access, .drop_disabled, .drop_reserved,
   .timeout, .load_taps
);

`default_nettype wire

//--- dv/erx_tb.sv
/* erx testbench
   table of register, receive, idle, reset and tap steps against a reference model */

`default_nettype none

module erx_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int rfaw     = 6;
   localparam int op_write = 0;
   localparam int op_read  = 1;
   localparam int op_rx    = 2;
   localparam int op_idle  = 3;
   localparam int op_reset = 4;
   localparam int op_taps  = 5;

   logic                      clk, reset, mi_en, mi_we;
   erx_txn_pkg::mi_addr_t     mi_addr;
   erx_txn_pkg::mi_data_t     mi_din, mi_dout;
   logic                      rx_access, rx_write, out_access, out_write;
   erx_txn_pkg::rx_addr_t     rx_dstaddr, out_dstaddr;
   erx_txn_pkg::rx_data_t     rx_data, out_data;
   erx_txn_pkg::link_status_t link_status;
   logic [8:0]                gpio_datain;
   logic                      mmu_enable, load_taps;
   erx_txn_pkg::idelay_t      idelay_value;

   // step table, one entry per row
   int          kind_q[$];
   string       name_q[$];
   logic [31:0] arg_a_q[$];                // word index, address or cycle count
   logic [31:0] arg_b_q[$];                // write data or rx data
   logic        flag_q[$];                 // rx_write

   // reference model
   logic [31:0] m_cfg, m_offset, m_testdata, m_idelay0;
   logic [12:0] m_idelay1;
   logic [2:0]  m_sticky;
   int          m_quiet;                   // idle cycles seen by the timer
   logic [31:0] lcg_state;
   int          error_count;

   erx_top #(.rfaw(rfaw)) i_erx_top (
      .clk, .reset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .rx_access, .rx_write, .rx_dstaddr, .rx_data,
      .out_access, .out_write, .out_dstaddr, .out_data,
      .link_status, .gpio_datain, .mmu_enable, .idelay_value, .load_taps
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ####################
   // reporting
   task automatic fail_now(input string what);
      error_count++;
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input erx_txn_pkg::mi_data_t exp,
                             input erx_txn_pkg::mi_data_t act);
      if (exp !== act) fail_now($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input erx_txn_pkg::rx_addr_t exp,
                             input erx_txn_pkg::rx_addr_t act);
      if (exp !== act) fail_now($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_data(input string name, input erx_txn_pkg::rx_data_t exp,
                             input erx_txn_pkg::rx_data_t act);
      if (exp !== act) fail_now($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_taps(input string name, input erx_txn_pkg::idelay_t exp,
                             input erx_txn_pkg::idelay_t act);
      if (exp !== act) fail_now($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) fail_now($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
   endtask

   // ####################
   // model helpers
   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] cfg_word(input logic en, input logic tst,
                                            input erx_txn_pkg::remap_mode_e mode,
                                            input logic [11:0] sel, input logic [11:0] pat,
                                            input logic [1:0] tmr);
      logic [31:0] w;
      w = '0;
      w[erx_regmap_pkg::cfg_rx_enable_bit]          = en;
      w[erx_regmap_pkg::cfg_test_mode_bit]          = tst;
      w[erx_regmap_pkg::cfg_remap_mode_lsb +: 2]    = mode;
      w[erx_regmap_pkg::cfg_remap_sel_lsb +: 12]    = sel;
      w[erx_regmap_pkg::cfg_remap_pattern_lsb +: 12] = pat;
      w[erx_regmap_pkg::cfg_timer_lsb +: 2]         = tmr;
      return w;
   endfunction

   function automatic int timer_limit(input logic [1:0] tmr);
      case (tmr)
         2'd1:    return 64;
         2'd2:    return 256;
         default: return 1024;
      endcase
   endfunction

   function automatic erx_txn_pkg::mi_data_t model_read(input logic [5:0] idx);
      case (idx)
         erx_regmap_pkg::reg_cfg:      return m_cfg;
         erx_regmap_pkg::reg_gpio:     return {23'd0, gpio_datain};
         erx_regmap_pkg::reg_status:   return {16'd0, link_status, m_sticky};
         erx_regmap_pkg::reg_offset:   return m_offset;
         erx_regmap_pkg::reg_testdata: return m_testdata;
         default:                      return '0;   // idelay words and holes
      endcase
   endfunction

   // static rewrite per bit, dynamic add
   function automatic erx_txn_pkg::rx_addr_t remap_ref(input erx_txn_pkg::rx_addr_t addr);
      erx_txn_pkg::rx_addr_t    a;
      erx_txn_pkg::remap_mode_e mode;
      logic [11:0]              sel, pat;
      a    = addr;
      mode = erx_txn_pkg::remap_mode_e'(m_cfg[erx_regmap_pkg::cfg_remap_mode_lsb +: 2]);
      sel  = m_cfg[erx_regmap_pkg::cfg_remap_sel_lsb +: 12];
      pat  = m_cfg[erx_regmap_pkg::cfg_remap_pattern_lsb +: 12];
      if (mode == erx_txn_pkg::remap_static) begin
         for (int i = 0; i < 12; i++) begin
            if (sel[i]) a[20+i] = pat[i];
         end
      end else if (mode == erx_txn_pkg::remap_dynamic) begin
         a = addr + m_offset;               // wraps
      end
      return a;
   endfunction

   // tap n: low nibble from word bits 4n+3:4n, msb from bit 36+n
   function automatic erx_txn_pkg::idelay_t taps_ref();
      erx_txn_pkg::idelay_t v;
      for (int n = 0; n < 9; n++) begin
         if (n < 8) v[5*n +: 4] = m_idelay0[4*n +: 4];
         else v[5*n +: 4] = m_idelay1[3:0];  // frame tap in word 1
         v[5*n+4] = m_idelay1[4+n];
      end
      return v;
   endfunction

   // ####################
   // bus and receive drivers
   task automatic step();
      logic [1:0] tmr;
      @(posedge clk);
      #10;                                  // drive point
      tmr = m_cfg[erx_regmap_pkg::cfg_timer_lsb +: 2];
      if (tmr == 2'd0) begin
         m_quiet = 0;
      end else begin
         m_quiet++;
         if (m_quiet >= timer_limit(tmr)) begin
            m_sticky[erx_regmap_pkg::st_timeout_bit] = 1'b1;
            m_quiet = 0;
         end
      end
   endtask

   task automatic apply_reset();
      reset     = 1'b1;
      m_cfg     = '0;
      m_sticky  = '0;
      m_idelay0 = '0;
      m_idelay1 = '0;
      m_quiet   = 0;
      repeat (8) step();
      reset = 1'b0;
   endtask

   task automatic bus_write(input logic [5:0] idx, input logic [31:0] data);
      step();
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = erx_txn_pkg::mi_addr_t'(idx) << 2;
      mi_din  = data;
      step();                               // write edge passed
      mi_en = 1'b0;
      mi_we = 1'b0;
      case (idx)
         erx_regmap_pkg::reg_cfg:      m_cfg = data;
         erx_regmap_pkg::reg_offset:   m_offset = data;
         erx_regmap_pkg::reg_idelay0:  m_idelay0 = data;
         erx_regmap_pkg::reg_idelay1:  m_idelay1 = data[12:0];
         erx_regmap_pkg::reg_testdata: m_testdata = data;
         default: ;
      endcase
      if (idx == erx_regmap_pkg::reg_cfg)
         check_bit("mmu pin", m_cfg[erx_regmap_pkg::cfg_mmu_bit], mmu_enable);
   endtask

   task automatic bus_read(input string name, input logic [5:0] idx);
      step();
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = erx_txn_pkg::mi_addr_t'(idx) << 2;
      step();                               // data registered here
      mi_en = 1'b0;
      check_word(name, model_read(idx), mi_dout);
      step();
      check_word({name, " idle"}, '0, mi_dout);
   endtask

   task automatic rx_send(input string name, input erx_txn_pkg::rx_addr_t addr,
                          input erx_txn_pkg::rx_data_t data, input logic wr);
      erx_txn_pkg::rx_addr_t exp_addr;
      logic                  fwd;
      int                    waited;
      exp_addr = remap_ref(addr);
      fwd      = 1'b0;
      // priority: disabled, test, reserved, forward
      if (!m_cfg[erx_regmap_pkg::cfg_rx_enable_bit])
         m_sticky[erx_regmap_pkg::st_drop_disabled_bit] = 1'b1;
      else if (m_cfg[erx_regmap_pkg::cfg_test_mode_bit])
         m_testdata = m_testdata + data;
      else if (m_cfg[erx_regmap_pkg::cfg_remap_mode_lsb +: 2] == erx_txn_pkg::remap_reserved)
         m_sticky[erx_regmap_pkg::st_drop_reserved_bit] = 1'b1;
      else
         fwd = 1'b1;
      step();
      rx_access  = 1'b1;
      rx_write   = wr;
      rx_dstaddr = addr;
      rx_data    = data;
      step();
      rx_access = 1'b0;
      m_quiet   = 0;                        // activity restarts the timer
      if (fwd) begin
         waited = 0;
         while (!out_access && waited < 4) begin
            step();
            waited++;
         end
         if (!out_access) fail_now({name, ": no out_access within 4 cycles"});
         check_bit({name, " latency"}, 1'b1, waited == 0);
         check_addr({name, " addr"}, exp_addr, out_dstaddr);
         check_bit({name, " write"}, wr, out_write);
         check_data({name, " data"}, data, out_data);
      end else begin
         check_bit({name, " not forwarded"}, 1'b0, out_access);
      end
   endtask

   task automatic tap_load(input string name, input logic [31:0] word1);
      int waited;
      bus_write(erx_regmap_pkg::reg_idelay1, word1);
      waited = 0;
      while (!load_taps && waited < 4) begin
         step();
         waited++;
      end
      if (!load_taps) fail_now({name, ": no load_taps within 4 cycles"});
      check_bit({name, " latency"}, 1'b1, waited == 0);
      check_taps(name, taps_ref(), idelay_value);
      step();
      check_bit({name, " single pulse"}, 1'b0, load_taps);
   endtask

   // ####################
   // table
   task automatic add_row(input int kind, input string name, input logic [31:0] a,
                          input logic [31:0] b, input logic flag);
      kind_q.push_back(kind);
      name_q.push_back(name);
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
      flag_q.push_back(flag);
   endtask

   task automatic add_rx(input string name, input int count);
      logic [31:0] a, d;
      for (int i = 0; i < count; i++) begin
         a = lcg_next();
         d = lcg_next();
         add_row(op_rx, name, a, d, a[7] ^ d[3]);
      end
   endtask

   task automatic build_table();
      logic [31:0] r;
      r = lcg_next();
      add_row(op_write, "cfg", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_none, r[11:0], r[27:16], 2'd0) | 32'h2,
              1'b0);
      add_row(op_read,  "cfg readback", erx_regmap_pkg::reg_cfg, 0, 1'b0);
      add_row(op_write, "offset", erx_regmap_pkg::reg_offset, lcg_next(), 1'b0);
      add_row(op_read,  "offset readback", erx_regmap_pkg::reg_offset, 0, 1'b0);
      add_row(op_write, "testdata", erx_regmap_pkg::reg_testdata, lcg_next(), 1'b0);
      add_row(op_read,  "testdata readback", erx_regmap_pkg::reg_testdata, 0, 1'b0);
      add_row(op_read,  "gpio readback", erx_regmap_pkg::reg_gpio, 0, 1'b0);
      add_row(op_read,  "idelay0 readback", erx_regmap_pkg::reg_idelay0, 0, 1'b0);
      add_row(op_read,  "unmapped 7", 7, 0, 1'b0);
      add_row(op_read,  "unmapped 63", 63, 0, 1'b0);
      add_rx("remap none", 4);
      r = lcg_next();
      add_row(op_write, "cfg static", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_static, r[11:0], r[27:16], 2'd0), 1'b0);
      add_rx("remap static", 4);
      add_row(op_write, "cfg dynamic", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_dynamic, 0, 0, 2'd0), 1'b0);
      add_rx("remap dynamic", 4);
      add_row(op_write, "cfg disabled", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b0, 1'b0, erx_txn_pkg::remap_none, 0, 0, 2'd0), 1'b0);
      add_rx("rx disabled", 2);
      add_row(op_read,  "status drop disabled", erx_regmap_pkg::reg_status, 0, 1'b0);
      add_row(op_write, "cfg reserved", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_reserved, 0, 0, 2'd0), 1'b0);
      add_rx("reserved mode", 2);
      add_row(op_read,  "status drop reserved", erx_regmap_pkg::reg_status, 0, 1'b0);
      add_row(op_write, "testdata start", erx_regmap_pkg::reg_testdata, lcg_next(), 1'b0);
      add_row(op_write, "cfg test", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b1, erx_txn_pkg::remap_none, 0, 0, 2'd0), 1'b0);
      add_rx("test mode", 5);
      add_row(op_read,  "testdata sum", erx_regmap_pkg::reg_testdata, 0, 1'b0);
      add_row(op_write, "cfg timer 64", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_none, 0, 0, 2'd1), 1'b0);
      add_row(op_idle,  "silence 70", 70, 0, 1'b0);
      add_row(op_read,  "status timeout", erx_regmap_pkg::reg_status, 0, 1'b0);
      add_row(op_write, "cfg timer off", erx_regmap_pkg::reg_cfg,
              cfg_word(1'b1, 1'b0, erx_txn_pkg::remap_none, 0, 0, 2'd0), 1'b0);
      add_row(op_reset, "reset", 0, 0, 1'b0);
      add_row(op_idle,  "silence 1100", 1100, 0, 1'b0);   // past the longest limit
      add_row(op_read,  "status after reset", erx_regmap_pkg::reg_status, 0, 1'b0);
      add_row(op_write, "idelay0", erx_regmap_pkg::reg_idelay0, lcg_next(), 1'b0);
      add_row(op_taps,  "tap load", 0, lcg_next(), 1'b0);
   endtask

   // ####################
   // main sequence
   initial begin
      reset       = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      rx_access   = 1'b0;
      rx_write    = 1'b0;
      rx_dstaddr  = '0;
      rx_data     = '0;
      link_status = 13'h0b5a;               // arbitrary live pins
      gpio_datain = 9'h1a5;
      lcg_state   = 32'd71;
      error_count = 0;
      build_table();
      apply_reset();
      for (int i = 0; i < kind_q.size(); i++) begin
         case (kind_q[i])
            op_write: bus_write(arg_a_q[i], arg_b_q[i]);
            op_read:  bus_read(name_q[i], arg_a_q[i]);
            op_rx:    rx_send(name_q[i], arg_a_q[i], arg_b_q[i], flag_q[i]);
            op_idle:  repeat (arg_a_q[i]) step();
            op_reset: apply_reset();
            op_taps:  tap_load(name_q[i], arg_b_q[i]);
            default:  fail_now("unknown row kind in the step table");
         endcase
      end
      repeat (2) step();
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         fail_now("errors were counted during the run");
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
logic/erx_regmap_pkg.sv
logic/erx_txn_pkg.sv
logic/erx_cfg.sv
logic/erx_remap.sv
logic/erx_timer.sv
logic/erx_top.sv
dv/erx_chk.sv
dv/erx_tb.sv

//--- logic/erx_cfg.sv
/* erx configuration register file
   write decode, config fields, test accumulator, sticky status, readback */

`default_nettype none

module erx_cfg #(
   parameter int rfaw = 6                           // word index width
) (
   input  wire                             clk,
   input  wire                             reset,
   // register bus
   input  wire                             mi_en,
   input  wire                             mi_we,
   input  wire erx_txn_pkg::mi_addr_t      mi_addr,
   input  wire erx_txn_pkg::mi_data_t      mi_din,
   output erx_txn_pkg::mi_data_t           mi_dout,
   // test accumulator feed
   input  wire                             test_access,
   input  wire erx_txn_pkg::rx_data_t      test_data,
   // status events
   input  wire                             timeout,
   input  wire                             drop_disabled,
   input  wire                             drop_reserved,
   input  wire erx_txn_pkg::link_status_t  link_status,
   input  wire [8:0]                       gpio_datain,
   // config fields
   output logic                            rx_enable,
   output logic                            test_mode,
   output logic                            mmu_enable,
   output erx_txn_pkg::remap_mode_e        remap_mode,
   output erx_txn_pkg::remap_field_t       remap_sel,
   output erx_txn_pkg::remap_field_t       remap_pattern,
   output erx_txn_pkg::rx_addr_t           remap_base,
   output erx_txn_pkg::timer_cfg_t         timer_cfg,
   output erx_txn_pkg::idelay_t            idelay_value,
   output logic                            load_taps
);

   logic [rfaw-1:0]       word_idx;
   logic                  mi_write, mi_read;
   logic                  hit_cfg, hit_gpio, hit_status, hit_offset;
   logic                  hit_idelay0, hit_idelay1, hit_testdata;
   erx_txn_pkg::mi_data_t cfg_q;
   erx_txn_pkg::mi_data_t offset_q;
   erx_txn_pkg::mi_data_t testdata_q;
   erx_txn_pkg::idelay_t  idelay_q;        // raw tap words, 45 live bits
   logic [8:0]            gpio_q;
   logic [2:0]            status_q;        // sticky bits
   erx_txn_pkg::mi_data_t rd_word;

   // ####################
   // decode
   assign word_idx = mi_addr[rfaw+1:2];
   assign mi_write = mi_en & mi_we;
   assign mi_read  = mi_en & ~mi_we;

   assign hit_cfg      = (word_idx == rfaw'(erx_regmap_pkg::reg_cfg));
   assign hit_gpio     = (word_idx == rfaw'(erx_regmap_pkg::reg_gpio));
   assign hit_status   = (word_idx == rfaw'(erx_regmap_pkg::reg_status));
   assign hit_offset   = (word_idx == rfaw'(erx_regmap_pkg::reg_offset));
   assign hit_idelay0  = (word_idx == rfaw'(erx_regmap_pkg::reg_idelay0));
   assign hit_idelay1  = (word_idx == rfaw'(erx_regmap_pkg::reg_idelay1));
   assign hit_testdata = (word_idx == rfaw'(erx_regmap_pkg::reg_testdata));

   // ####################
   // receive control
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg_q <= '0;
      end else if (mi_write && hit_cfg) begin
         cfg_q <= mi_din;
      end
   end

   assign test_mode     = cfg_q[erx_regmap_pkg::cfg_test_mode_bit];
   assign mmu_enable    = cfg_q[erx_regmap_pkg::cfg_mmu_bit];     // pin only
   assign remap_mode    = erx_txn_pkg::remap_mode_e'(cfg_q[erx_regmap_pkg::cfg_remap_mode_lsb +: 2]);
   assign remap_sel     = cfg_q[erx_regmap_pkg::cfg_remap_sel_lsb +: 12];
   assign remap_pattern = cfg_q[erx_regmap_pkg::cfg_remap_pattern_lsb +: 12];
   assign timer_cfg     = cfg_q[erx_regmap_pkg::cfg_timer_lsb +: 2];
   assign rx_enable     = cfg_q[erx_regmap_pkg::cfg_rx_enable_bit];

   // dynamic remap base, payload
   always_ff @(posedge clk) begin
      if (mi_write && hit_offset) begin
         offset_q <= mi_din;
      end
   end
   assign remap_base = offset_q;

   // pins sampled every cycle
   always_ff @(posedge clk) begin
      gpio_q <= gpio_datain;
   end

   // sticky status, set by strobes
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         status_q <= '0;
      end else begin
         if (timeout)       status_q[erx_regmap_pkg::st_timeout_bit]       <= 1'b1;
         if (drop_disabled) status_q[erx_regmap_pkg::st_drop_disabled_bit] <= 1'b1;
         if (drop_reserved) status_q[erx_regmap_pkg::st_drop_reserved_bit] <= 1'b1;
      end
   end

   // ####################
   // idelay taps
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idelay_q <= '0;
      end else if (mi_write && hit_idelay0) begin
         idelay_q[31:0] <= mi_din;
      end else if (mi_write && hit_idelay1) begin
         idelay_q[44:32] <= mi_din[12:0];     // frame nibble + 9 tap msbs
      end
   end

   // tap n = {bit 36+n, bits 4n+3:4n}
   always_comb begin
      for (int n = 0; n < 9; n++) begin
         idelay_value[5*n +: 5] = {idelay_q[36+n], idelay_q[4*n +: 4]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         load_taps <= 1'b0;
      end else begin
         load_taps <= mi_write & hit_idelay1;   // one cycle after the write
      end
   end

   // ####################
   // test accumulator, bus write wins over add
   always_ff @(posedge clk) begin
      if (mi_write && hit_testdata) begin
         testdata_q <= mi_din;
      end else if (test_access) begin
         testdata_q <= testdata_q + test_data; // wraps mod 2^32
      end
   end

   // ####################
   // readback
   always_comb begin
      rd_word = '0;                            // unmapped reads as zero
      if (hit_cfg)      rd_word = cfg_q;
      if (hit_gpio)     rd_word = {23'd0, gpio_q};
      if (hit_status)   rd_word = {16'd0, link_status, status_q};
      if (hit_offset)   rd_word = offset_q;
      if (hit_testdata) rd_word = testdata_q;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mi_dout <= '0;
      end else begin
         mi_dout <= mi_read ? rd_word : '0;     // zero unless a read preceded
      end
   end

endmodule

`default_nettype wire

//--- logic/erx_regmap_pkg.sv
/* erx register map
   word indices, control register fields and sticky status bit positions */

`default_nettype none

package erx_regmap_pkg;

   // ####################
   // word indices (byte address bits rfaw+1:2)
   localparam logic [5:0] reg_cfg      = 6'd0; // receive control
   localparam logic [5:0] reg_gpio     = 6'd1; // sampled pins, read only
   localparam logic [5:0] reg_status   = 6'd2; // sticky + live status
   localparam logic [5:0] reg_offset   = 6'd3; // dynamic remap base
   localparam logic [5:0] reg_idelay0  = 6'd4; // low tap nibbles
   localparam logic [5:0] reg_idelay1  = 6'd5; // frame nibble + msbs
   localparam logic [5:0] reg_testdata = 6'd6; // test accumulator

   // ####################
   // receive control fields
   localparam int cfg_test_mode_bit     = 0;
   localparam int cfg_mmu_bit           = 1;
   localparam int cfg_remap_mode_lsb    = 2;  // 2 bits
   localparam int cfg_remap_sel_lsb     = 4;  // 12 bits
   localparam int cfg_remap_pattern_lsb = 16; // 12 bits
   localparam int cfg_timer_lsb         = 28; // 2 bits
   localparam int cfg_rx_enable_bit     = 30;

   // sticky status, cleared by reset only
   localparam int st_timeout_bit       = 0;
   localparam int st_drop_disabled_bit = 1;
   localparam int st_drop_reserved_bit = 2;

endpackage

`default_nettype wire

//--- logic/erx_remap.sv
/* erx receive remap stage
   gates, diverts test traffic, rewrites the destination address */

`default_nettype none

module erx_remap (
   input  wire                             clk,
   input  wire                             reset,
   // incoming transaction
   input  wire                             rx_access,
   input  wire                             rx_write,
   input  wire erx_txn_pkg::rx_addr_t      rx_dstaddr,
   input  wire erx_txn_pkg::rx_data_t      rx_data,
   // config
   input  wire                             rx_enable,
   input  wire                             test_mode,
   input  wire erx_txn_pkg::remap_mode_e   remap_mode,
   input  wire erx_txn_pkg::remap_field_t  remap_sel,
   input  wire erx_txn_pkg::remap_field_t  remap_pattern,
   input  wire erx_txn_pkg::rx_addr_t      remap_base,
   // results, one cycle later
   output logic                            out_access,
   output logic                            out_write,
   output erx_txn_pkg::rx_addr_t           out_dstaddr,
   output erx_txn_pkg::rx_data_t           out_data,
   output logic                            test_access,
   output erx_txn_pkg::rx_data_t           test_data,
   output logic                            drop_disabled,
   output logic                            drop_reserved
);

   erx_txn_pkg::rx_addr_t static_addr;
   erx_txn_pkg::rx_addr_t new_addr;
   erx_txn_pkg::rx_data_t data_q;          // shared by both payload outputs
   logic                  live, is_reserved;

   // static: selected upper bits take the pattern
   always_comb begin
      static_addr        = rx_dstaddr;
      static_addr[31:20] = (rx_dstaddr[31:20] & ~remap_sel) | (remap_pattern & remap_sel);
   end

   always_comb begin
      case (remap_mode)
         erx_txn_pkg::remap_static:  new_addr = static_addr;
         erx_txn_pkg::remap_dynamic: new_addr = rx_dstaddr + remap_base; // mod 2^32
         default:                    new_addr = rx_dstaddr;
      endcase
   end

   // ####################
   // classify, priority order
   assign live        = rx_access & rx_enable;
   assign is_reserved = (remap_mode == erx_txn_pkg::remap_reserved);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         out_access    <= 1'b0;
         test_access   <= 1'b0;
         drop_disabled <= 1'b0;
         drop_reserved <= 1'b0;
      end else begin
         drop_disabled <= rx_access & ~rx_enable;
         test_access   <= live & test_mode;
         drop_reserved <= live & ~test_mode & is_reserved;
         out_access    <= live & ~test_mode & ~is_reserved;
      end
   end

   // payload, captured on every strobe
   always_ff @(posedge clk) begin
      if (rx_access) begin
         out_write   <= rx_write;
         out_dstaddr <= new_addr;
         data_q      <= rx_data;
      end
   end

   assign out_data  = data_q;
   assign test_data = data_q;

endmodule

`default_nettype wire

//--- logic/erx_timer.sv
/* erx inactivity timer
   flags receive silence of 64, 256 or 1024 cycles with a one-cycle strobe */

`default_nettype none

module erx_timer (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           rx_access,   // any activity restarts
   input  wire erx_txn_pkg::timer_cfg_t  timer_cfg,   // 0 = off
   output logic                          timeout
);

   logic [9:0] count;
   logic [9:0] last;                       // limit minus one

   // limit select
   always_comb begin
      case (timer_cfg)
         2'd1:    last = 10'd63;
         2'd2:    last = 10'd255;
         default: last = 10'd1023;         // cfg 0 never counts
      endcase
   end

   // ####################
   // counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count   <= '0;
         timeout <= 1'b0;
      end else begin
         timeout <= 1'b0;
         if (timer_cfg == 2'd0 || rx_access) begin
            count <= '0;                   // held off or restarted
         end else if (count == last) begin
            count   <= '0;                 // wrap and flag
            timeout <= 1'b1;
         end else begin
            count <= count + 10'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/erx_top.sv
/* erx receive config slice
   register file, remap stage and inactivity timer */

`default_nettype none

module erx_top #(
   parameter int rfaw = 6
) (
   input  wire                             clk,
   input  wire                             reset,
   // register bus
   input  wire                             mi_en,
   input  wire                             mi_we,
   input  wire erx_txn_pkg::mi_addr_t      mi_addr,
   input  wire erx_txn_pkg::mi_data_t      mi_din,
   output erx_txn_pkg::mi_data_t           mi_dout,
   // receive path
   input  wire                             rx_access,
   input  wire                             rx_write,
   input  wire erx_txn_pkg::rx_addr_t      rx_dstaddr,
   input  wire erx_txn_pkg::rx_data_t      rx_data,
   output logic                            out_access,
   output logic                            out_write,
   output erx_txn_pkg::rx_addr_t           out_dstaddr,
   output erx_txn_pkg::rx_data_t           out_data,
   // pins
   input  wire erx_txn_pkg::link_status_t  link_status,
   input  wire [8:0]                       gpio_datain,
   output logic                            mmu_enable,
   output erx_txn_pkg::idelay_t            idelay_value,
   output logic                            load_taps
);

   // config fields
   logic                      rx_enable, test_mode;
   erx_txn_pkg::remap_mode_e  remap_mode;
   erx_txn_pkg::remap_field_t remap_sel, remap_pattern;
   erx_txn_pkg::rx_addr_t     remap_base;
   erx_txn_pkg::timer_cfg_t   timer_cfg;
   // events into the register file
   logic                      test_access, drop_disabled, drop_reserved, timeout;
   erx_txn_pkg::rx_data_t     test_data;

   // ####################
   erx_cfg #(.rfaw(rfaw)) i_cfg (
      .clk, .reset,
      .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .test_access, .test_data,
      .timeout, .drop_disabled, .drop_reserved,
      .link_status, .gpio_datain,
      .rx_enable, .test_mode, .mmu_enable,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .timer_cfg, .idelay_value, .load_taps
   );

   erx_remap i_remap (
      .clk, .reset,
      .rx_access, .rx_write, .rx_dstaddr, .rx_data,
      .rx_enable, .test_mode,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .out_access, .out_write, .out_dstaddr, .out_data,
      .test_access, .test_data,
      .drop_disabled, .drop_reserved
   );

   // watches raw receive strobes
   erx_timer i_timer (
      .clk, .reset,
      .rx_access, .timer_cfg,
      .timeout
   );

endmodule

`default_nettype wire

//--- logic/erx_txn_pkg.sv
/* erx transaction types
   address, data, tap and timer widths plus the remap mode encoding */

`default_nettype none

package erx_txn_pkg;

   // receive side
   typedef logic [31:0] rx_addr_t;     // destination address
   typedef logic [31:0] rx_data_t;     // payload word

   // register bus
   typedef logic [14:0] mi_addr_t;     // byte address
   typedef logic [31:0] mi_data_t;

   // ####################
   // configuration fields
   typedef logic [11:0] remap_field_t; // upper address bits 31:20
   typedef logic [44:0] idelay_t;      // 9 taps x 5 bits, frame on top
   typedef logic [1:0]  timer_cfg_t;   // 0 = off
   typedef logic [12:0] link_status_t; // live pins, status bits 15:3

   // remap mode field values
   typedef enum logic [1:0] {
      remap_none     = 2'd0,
      remap_static   = 2'd1,
      remap_dynamic  = 2'd2,
      remap_reserved = 2'd3   // traffic dropped
   } remap_mode_e;

endpackage

`default_nettype wire
